// ==== lcd_pkg.sv ====
// LCD2004 driver shared definitions
// command opcodes, FSM state encodings, timing and geometry constants
package lcd_pkg;

    // ======================================================================
    // basic types
    // ======================================================================
    typedef logic [7:0] ascii_t;
    typedef logic [3:0] nibble_t;

    // HD44780 command bytes used by this driver
    typedef enum logic [7:0] {
        INIT_8BIT  = 8'h33,
        INIT_4BIT  = 8'h32,
        FUNC_SET   = 8'h28,
        DISP_ON    = 8'h0C,
        ENTRY_MODE = 8'h06,
        CLEAR      = 8'h01,
        LINE1      = 8'h80,
        LINE2      = 8'hC0,
        LINE3      = 8'h94,
        LINE4      = 8'hD4
    } lcd_cmd_e;

    typedef enum logic [2:0] {
        BOOT_WAIT, INIT, WAIT_SERIAL, SEND_ADDR, SEND_CHAR, REFRESH_WAIT
    } seq_state_e;

    // sender states; the high/low nibble flag lives next to the state reg
    typedef enum logic [2:0] {
        IDLE, SETUP, EN_HIGH, HOLD, POST_WAIT
    } send_state_e;

    // ======================================================================
    // timing, in microsecond ticks
    // ======================================================================
    localparam int PULSE_US       = 2;
    localparam int WAIT_US_NORMAL = 40;
    // clear and the two wake-up bytes need >1.53 ms
    localparam int WAIT_US_LONG   = 2000;

    // display geometry
    localparam int LINE_CHARS   = 20;
    localparam int NUM_LINES    = 4;
    localparam int MSG_CHARS    = 60;
    localparam int SERIAL_CHARS = 6;

    // power-up command list, sent once in this order
    localparam int INIT_LEN = 6;
    localparam lcd_cmd_e INIT_CMDS [INIT_LEN] = '{
        INIT_8BIT, INIT_4BIT, FUNC_SET, DISP_ON, ENTRY_MODE, CLEAR
    };

endpackage

// ==== lcd_byte_if.sv ====
// LCD byte channel
// one command or character byte from the frame sequencer to the nibble sender
`timescale 1ns/1ps

interface lcd_byte_if;

    logic           valid;
    logic           ready;
    // 1 = character (rs high), 0 = command
    logic           is_data;
    lcd_pkg::ascii_t data;

    modport master (
        output valid, is_data, data,
        input  ready
    );

    modport slave (
        input  valid, is_data, data,
        output ready
    );

endinterface

// ==== lcd_tick_gen.sv ====
// Microsecond tick generator
// one-cycle tick_o pulse every CLK_HZ/1e6 clock cycles
`timescale 1ns/1ps

module lcd_tick_gen #(
    parameter int CLK_HZ = 50_000_000
) (
    input  logic clk,
    input  logic rst,
    output logic tick_o
);

    localparam int DIV   = (CLK_HZ / 1_000_000 > 1) ? CLK_HZ / 1_000_000 : 2;
    localparam int CNT_W = $clog2(DIV);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt    <= '0;
            tick_o <= 1'b0;
        end else if (cnt == CNT_W'(DIV - 1)) begin
            cnt    <= '0;
            tick_o <= 1'b1;
        end else begin
            cnt    <= cnt + 1'b1;
            tick_o <= 1'b0;
        end
    end

endmodule

// ==== lcd_char_map.sv ====
// Frame character map
// combinational lookup of the ASCII code shown at a given row and column
`timescale 1ns/1ps

module lcd_char_map (
    input  logic [1:0]      row_i,
    input  logic [4:0]      col_i,
    input  logic [47:0]     serial_i,
    input  lcd_pkg::ascii_t chance_i,
    input  logic [479:0]    msg_i,
    output lcd_pkg::ascii_t char_o
);

    import lcd_pkg::*;

    logic [2:0] sn_idx;
    logic [5:0] msg_idx;
    ascii_t     serial_char;
    ascii_t     msg_char;

    // serial chars sit at columns 4..9, first char in the top byte
    assign sn_idx      = 3'(col_i - 5'd4);
    assign serial_char = serial_i[SERIAL_CHARS*8-1 - 8*sn_idx -: 8];

    // rows 1..3 walk the message, 20 chars per row
    assign msg_idx  = 6'(row_i * LINE_CHARS + col_i - LINE_CHARS);
    assign msg_char = msg_i[MSG_CHARS*8-1 - 8*msg_idx -: 8];

    always_comb begin
        char_o = " ";
        if (row_i == 2'd0) begin
            // "SN: xxxxxx chance: d"
            case (col_i)
                5'd0:  char_o = "S";
                5'd1:  char_o = "N";
                5'd2:  char_o = ":";
                5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9: char_o = serial_char;
                5'd11: char_o = "c";
                5'd12: char_o = "h";
                5'd13: char_o = "a";
                5'd14: char_o = "n";
                5'd15: char_o = "c";
                5'd16: char_o = "e";
                5'd17: char_o = ":";
                5'd19: char_o = chance_i;
                default: char_o = " ";
            endcase
        end else begin
            char_o = msg_char;
        end
    end

endmodule

// ==== lcd_frame_sequencer.sv ====
// LCD frame sequencer
// boot delay, init command list, then an endless refresh of all four lines
// with a wait between frames; inputs are latched once per frame
`timescale 1ns/1ps

module lcd_frame_sequencer #(
    parameter int BOOT_WAIT_US    = 20_000,
    parameter int REFRESH_WAIT_US = 200_000
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              tick_i,
    input  logic              serial_done_i,
    input  logic [47:0]       serial_number_i,
    input  lcd_pkg::ascii_t   chance_ascii_i,
    input  logic [479:0]      msg_i,
    output logic              activated_o,
    lcd_byte_if.master        byte_if
);

    import lcd_pkg::*;

    seq_state_e   state;
    logic [31:0]  wait_cnt;
    logic [2:0]   init_idx;
    logic [1:0]   row;
    logic [4:0]   col;
    logic         xfer;
    logic         latch_en;
    logic [47:0]  serial_q;
    ascii_t       chance_q;
    logic [479:0] msg_q;
    ascii_t       map_char;
    ascii_t       line_addr;

    assign xfer = byte_if.valid && byte_if.ready;

    // new frame values are taken exactly when a frame starts
    assign latch_en = ((state == WAIT_SERIAL) && serial_done_i) ||
                      ((state == REFRESH_WAIT) && (wait_cnt == '0));

    always_comb begin
        case (row)
            2'd0:    line_addr = LINE1;
            2'd1:    line_addr = LINE2;
            2'd2:    line_addr = LINE3;
            default: line_addr = LINE4;
        endcase
    end

    lcd_char_map u_char_map (
        .row_i    (row),
        .col_i    (col),
        .serial_i (serial_q),
        .chance_i (chance_q),
        .msg_i    (msg_q),
        .char_o   (map_char)
    );

    always_ff @(posedge clk) begin
        if (latch_en) begin
            serial_q <= serial_number_i;
            chance_q <= chance_ascii_i;
            msg_q    <= msg_i;
        end
    end

    // ======================================================================
    // main FSM
    // ======================================================================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state           <= BOOT_WAIT;
            wait_cnt        <= 32'(BOOT_WAIT_US);
            init_idx        <= '0;
            row             <= '0;
            col             <= '0;
            activated_o     <= 1'b0;
            byte_if.valid   <= 1'b0;
            byte_if.is_data <= 1'b0;
            byte_if.data    <= '0;
        end else begin
            case (state)
                BOOT_WAIT: begin
                    if (wait_cnt == '0) state <= INIT;
                    else if (tick_i)    wait_cnt <= wait_cnt - 1'b1;
                end
                INIT: begin
                    if (!byte_if.valid) begin
                        byte_if.valid   <= 1'b1;
                        byte_if.is_data <= 1'b0;
                        byte_if.data    <= INIT_CMDS[init_idx];
                    end else if (xfer) begin
                        byte_if.valid <= 1'b0;
                        init_idx      <= init_idx + 1'b1;
                        if (init_idx == 3'(INIT_LEN - 1)) state <= WAIT_SERIAL;
                    end
                end
                WAIT_SERIAL: begin
                    if (serial_done_i) begin
                        row   <= '0;
                        state <= SEND_ADDR;
                    end
                end
                SEND_ADDR: begin
                    if (!byte_if.valid) begin
                        byte_if.valid   <= 1'b1;
                        byte_if.is_data <= 1'b0;
                        byte_if.data    <= line_addr;
                    end else if (xfer) begin
                        byte_if.valid <= 1'b0;
                        col           <= '0;
                        state         <= SEND_CHAR;
                        if (row == 2'd0) activated_o <= 1'b1;
                    end
                end
                SEND_CHAR: begin
                    if (!byte_if.valid) begin
                        byte_if.valid   <= 1'b1;
                        byte_if.is_data <= 1'b1;
                        byte_if.data    <= map_char;
                    end else if (xfer) begin
                        byte_if.valid <= 1'b0;
                        if (col != 5'(LINE_CHARS - 1)) begin
                            col <= col + 1'b1;
                        end else if (row == 2'(NUM_LINES - 1)) begin
                            wait_cnt <= 32'(REFRESH_WAIT_US);
                            state    <= REFRESH_WAIT;
                        end else begin
                            row   <= row + 1'b1;
                            state <= SEND_ADDR;
                        end
                    end
                end
                REFRESH_WAIT: begin
                    if (wait_cnt == '0) begin
                        row   <= '0;
                        state <= SEND_ADDR;
                    end else if (tick_i) begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                default: state <= BOOT_WAIT;
            endcase
        end
    end

endmodule

// ==== lcd_nibble_sender.sv ====
// HD44780 4-bit nibble sender
// sends each byte as high then low nibble with timed enable pulses,
// then holds off for a fixed post-delay instead of polling busy
`timescale 1ns/1ps

module lcd_nibble_sender (
    input  logic             clk,
    input  logic             rst,
    input  logic             tick_i,
    lcd_byte_if.slave        byte_if,
    output logic             lcd_rs_o,
    output logic             lcd_en_o,
    output lcd_pkg::nibble_t lcd_data_o
);

    import lcd_pkg::*;

    localparam int CNT_W = $clog2(WAIT_US_LONG + 1);

    send_state_e      state;
    // 0 = high nibble on the bus, 1 = low nibble
    logic             lo_nibble;
    logic [CNT_W-1:0] cnt;
    logic             long_wait;
    logic             is_slow_cmd;
    nibble_t          lo_data;

    // these commands need the long post-delay
    assign is_slow_cmd = !byte_if.is_data &&
                         ((byte_if.data == CLEAR) ||
                          (byte_if.data == INIT_8BIT) ||
                          (byte_if.data == INIT_4BIT));

    assign byte_if.ready = (state == IDLE);

    always_ff @(posedge clk) begin
        if ((state == IDLE) && byte_if.valid) begin
            lo_data <= byte_if.data[3:0];
        end
    end

    // ======================================================================
    // nibble timing FSM
    // each phase counts PULSE_US+1 ticks
    // ======================================================================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= IDLE;
            lo_nibble  <= 1'b0;
            cnt        <= '0;
            long_wait  <= 1'b0;
            lcd_rs_o   <= 1'b0;
            lcd_en_o   <= 1'b0;
            lcd_data_o <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (byte_if.valid) begin
                        lcd_rs_o   <= byte_if.is_data;
                        lcd_data_o <= byte_if.data[7:4];
                        long_wait  <= is_slow_cmd;
                        lo_nibble  <= 1'b0;
                        cnt        <= CNT_W'(PULSE_US);
                        state      <= SETUP;
                    end
                end
                SETUP: begin
                    if (tick_i) begin
                        if (cnt != '0) begin
                            cnt <= cnt - 1'b1;
                        end else begin
                            lcd_en_o <= 1'b1;
                            cnt      <= CNT_W'(PULSE_US);
                            state    <= EN_HIGH;
                        end
                    end
                end
                EN_HIGH: begin
                    if (tick_i) begin
                        if (cnt != '0) begin
                            cnt <= cnt - 1'b1;
                        end else begin
                            lcd_en_o <= 1'b0;
                            cnt      <= CNT_W'(PULSE_US);
                            state    <= HOLD;
                        end
                    end
                end
                HOLD: begin
                    if (tick_i) begin
                        if (cnt != '0) begin
                            cnt <= cnt - 1'b1;
                        end else if (!lo_nibble) begin
                            lo_nibble  <= 1'b1;
                            lcd_data_o <= lo_data;
                            cnt        <= CNT_W'(PULSE_US);
                            state      <= SETUP;
                        end else begin
                            cnt   <= long_wait ? CNT_W'(WAIT_US_LONG) : CNT_W'(WAIT_US_NORMAL);
                            state <= POST_WAIT;
                        end
                    end
                end
                POST_WAIT: begin
                    // controller still executing the byte
                    if (tick_i) begin
                        if (cnt != '0) cnt <= cnt - 1'b1;
                        else           state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== lcd2004_driver.sv ====
// LCD2004 driver top level
// 20x4 HD44780 display over the 4-bit bus: tick source, frame sequencer
// and nibble sender
`timescale 1ns/1ps

module lcd2004_driver #(
    parameter int CLK_HZ          = 50_000_000,
    parameter int BOOT_WAIT_US    = 20_000,
    parameter int REFRESH_WAIT_US = 200_000
) (
    input  logic         clk,
    input  logic         rst,
    input  logic [47:0]  serial_number_i,
    input  logic         serial_done_i,
    input  logic [7:0]   chance_ascii_i,
    input  logic [479:0] msg_i,
    output logic         lcd_rs_o,
    output logic         lcd_en_o,
    output logic [3:0]   lcd_data_o,
    output logic         activated_o
);

    logic tick_us;

    lcd_byte_if byte_if ();

    lcd_tick_gen #(
        .CLK_HZ (CLK_HZ)
    ) u_tick_gen (
        .clk    (clk),
        .rst    (rst),
        .tick_o (tick_us)
    );

    lcd_frame_sequencer #(
        .BOOT_WAIT_US    (BOOT_WAIT_US),
        .REFRESH_WAIT_US (REFRESH_WAIT_US)
    ) u_sequencer (
        .clk             (clk),
        .rst             (rst),
        .tick_i          (tick_us),
        .serial_done_i   (serial_done_i),
        .serial_number_i (serial_number_i),
        .chance_ascii_i  (chance_ascii_i),
        .msg_i           (msg_i),
        .activated_o     (activated_o),
        .byte_if         (byte_if)
    );

    lcd_nibble_sender u_sender (
        .clk        (clk),
        .rst        (rst),
        .tick_i     (tick_us),
        .byte_if    (byte_if),
        .lcd_rs_o   (lcd_rs_o),
        .lcd_en_o   (lcd_en_o),
        .lcd_data_o (lcd_data_o)
    );

endmodule

// ==== lcd_sender_properties.sv ====
// Nibble sender assertions
// enable pulse width, bus stability and handshake while enable is high
`timescale 1ns/1ps

module lcd_sender_properties (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tick_i,
    input  lcd_pkg::send_state_e state_i,
    input  logic                 en_i,
    input  logic                 rs_i,
    input  logic [3:0]           data_i,
    input  logic                 ready_i
);

    import lcd_pkg::*;

    int en_ticks;
    int fail_cnt = 0;

    // ticks seen while enable is high
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            en_ticks <= 0;
        end else if (!en_i) begin
            en_ticks <= 0;
        end else if (tick_i) begin
            en_ticks <= en_ticks + 1;
        end
    end

    a_bus_stable: assert property (@(posedge clk) disable iff (!rst)
        (en_i && $past(en_i)) |-> ($stable(rs_i) && $stable(data_i)))
        else begin
            fail_cnt++;
            $error("rs or data changed while enable was high");
        end

    a_pulse_width: assert property (@(posedge clk) disable iff (!rst)
        $fell(en_i) |-> (en_ticks >= PULSE_US + 1))
        else begin
            fail_cnt++;
            $error("enable pulse shorter than %0d ticks", PULSE_US + 1);
        end

    a_no_ready: assert property (@(posedge clk) disable iff (!rst)
        en_i |-> (!ready_i && (state_i == EN_HIGH)))
        else begin
            fail_cnt++;
            $error("ready high or wrong state during enable pulse");
        end

endmodule

bind lcd_nibble_sender lcd_sender_properties u_props (
    .clk     (clk),
    .rst     (rst),
    .tick_i  (tick_i),
    .state_i (state),
    .en_i    (lcd_en_o),
    .rs_i    (lcd_rs_o),
    .data_i  (lcd_data_o),
    .ready_i (byte_if.ready)
);

// ==== lcd_bus_monitor.sv ====
// LCD bus monitor
// rebuilds bytes from the 4-bit bus and checks them against a model frame
`timescale 1ns/1ps

module lcd_bus_monitor #(
    parameter int BOOT_WAIT_US    = 100,
    parameter int REFRESH_WAIT_US = 500
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         lcd_rs_i,
    input  logic         lcd_en_i,
    input  logic [3:0]   lcd_data_i,
    input  logic         activated_i,
    input  logic         serial_done_i,
    input  logic [47:0]  serial_number_i,
    input  logic [7:0]   chance_ascii_i,
    input  logic [479:0] msg_i,
    output logic         init_done_o,
    output int           frames_o,
    output int           value_errs_o,
    output int           timing_errs_o,
    output int           order_errs_o
);

    import lcd_pkg::*;

    localparam int FRAME_BYTES = NUM_LINES * (LINE_CHARS + 1);
    // HD44780 wake-up and setup bytes in power-up order
    localparam logic [7:0] INIT_BYTES [INIT_LEN] = '{
        8'h33, 8'h32, 8'h28, 8'h0C, 8'h06, 8'h01
    };
    // DDRAM start address of each line on a 20x4 panel
    localparam logic [7:0] LINE_ADDR [NUM_LINES] = '{8'h80, 8'hC0, 8'h94, 8'hD4};

    logic [3:0]   hi_nib;
    logic         hi_rs;
    logic         have_hi;
    logic         seen_en;
    logic         serial_seen;
    logic         act_flagged;
    logic         last_long;
    int           byte_cnt;
    int           frame_pos;
    realtime      rst_rel_t;
    realtime      byte_end_t;
    realtime      frame_end_t;
    // model frame contents taken when LINE1 shows up
    logic [159:0] row0_q;
    logic [479:0] msg_q;

    initial begin
        have_hi       = 1'b0;
        seen_en       = 1'b0;
        serial_seen   = 1'b0;
        act_flagged   = 1'b0;
        last_long     = 1'b0;
        byte_cnt      = 0;
        frame_pos     = 0;
        rst_rel_t     = 0.0;
        byte_end_t    = 0.0;
        frame_end_t   = 0.0;
        init_done_o   = 1'b0;
        frames_o      = 0;
        value_errs_o  = 0;
        timing_errs_o = 0;
        order_errs_o  = 0;
    end

    function automatic logic [7:0] model_byte(input int pos);
        int line;
        int col;
        line = pos / (LINE_CHARS + 1);
        col  = pos % (LINE_CHARS + 1) - 1;
        if (col < 0) return LINE_ADDR[line];
        if (line == 0) return row0_q[159 - 8*col -: 8];
        return msg_q[479 - 8*((line - 1)*LINE_CHARS + col) -: 8];
    endfunction

    task automatic check_byte(input logic [7:0] b, input logic rs);
        logic [7:0] exp_b;
        logic       exp_rs;
        if (byte_cnt < INIT_LEN) begin
            exp_b  = INIT_BYTES[byte_cnt];
            exp_rs = 1'b0;
        end else begin
            if (!serial_seen) begin
                order_errs_o++;
                $display("frame byte on the bus before serial_done_i was seen high");
            end
            if (frame_pos == 0) begin
                row0_q = {"SN: ", serial_number_i, " chance: ", chance_ascii_i};
                msg_q  = msg_i;
                if (!activated_i) begin
                    order_errs_o++;
                    $display("activated_o low at the LINE1 address of frame %0d", frames_o);
                end
                if (frames_o > 0 && ($realtime - frame_end_t) < REFRESH_WAIT_US * 1000.0) begin
                    timing_errs_o++;
                    $display("frame %0d started before the refresh wait elapsed", frames_o);
                end
            end
            exp_b  = model_byte(frame_pos);
            exp_rs = (frame_pos % (LINE_CHARS + 1)) != 0;
        end
        if (rs !== exp_rs) begin
            value_errs_o++;
            $display("FAILED lcd_rs_o byte %0d: got %h expected %h", byte_cnt, rs, exp_rs);
        end
        if (b !== exp_b) begin
            value_errs_o++;
            $display("FAILED lcd_data_o byte %0d: got %h expected %h", byte_cnt, b, exp_b);
        end
        // clear and the wake-up bytes get the long post-delay
        last_long  = !rs && (b == CLEAR || b == INIT_8BIT || b == INIT_4BIT);
        byte_end_t = $realtime;
        byte_cnt++;
        if (byte_cnt == INIT_LEN) init_done_o = 1'b1;
        else if (byte_cnt > INIT_LEN) frame_pos++;
        if (frame_pos == FRAME_BYTES) begin
            frame_pos   = 0;
            frame_end_t = $realtime;
            frames_o++;
        end
    endtask

    always @(posedge rst) rst_rel_t = $realtime;

    always @(posedge clk) begin
        if (rst && !serial_seen && activated_i && !act_flagged) begin
            act_flagged = 1'b1;
            order_errs_o++;
            $display("activated_o went high before serial_done_i");
        end
        if (rst && serial_done_i) serial_seen = 1'b1;
    end

    // minimum gaps after reset release and after each byte
    always @(posedge lcd_en_i) begin
        if (rst && !seen_en) begin
            seen_en = 1'b1;
            if (($realtime - rst_rel_t) < BOOT_WAIT_US * 1000.0) begin
                timing_errs_o++;
                $display("first enable pulse came before the boot wait elapsed");
            end
        end else if (rst && !have_hi) begin
            if (($realtime - byte_end_t) < (last_long ? WAIT_US_LONG : WAIT_US_NORMAL) * 1000.0) begin
                timing_errs_o++;
                $display("byte %0d started before the post-delay elapsed", byte_cnt);
            end
        end
    end

    always @(negedge lcd_en_i) begin
        if (rst && !have_hi) begin
            hi_nib  = lcd_data_i;
            hi_rs   = lcd_rs_i;
            have_hi = 1'b1;
        end else if (rst) begin
            have_hi = 1'b0;
            if (lcd_rs_i !== hi_rs) begin
                order_errs_o++;
                $display("rs changed between the two nibbles of byte %0d", byte_cnt);
            end
            check_byte({hi_nib, lcd_data_i}, lcd_rs_i);
        end
    end

endmodule

// ==== tb_lcd2004.sv ====
// LCD2004 driver testbench
// random frame contents from a fixed seed; bus checks live in the monitor
`timescale 1ns/1ps

module tb_lcd2004;

    import lcd_pkg::*;

    localparam int CLK_HZ          = 25_000_000;
    localparam int BOOT_WAIT_US    = 100;
    localparam int REFRESH_WAIT_US = 500;
    localparam int NUM_FRAMES      = 3;
    localparam int CYC_PER_US      = CLK_HZ / 1_000_000;
    localparam int SERIAL_MAX_US   = 4000;
    // two nibbles of three phases each plus handshake slack
    localparam int BYTE_US  = 6 * (PULSE_US + 1) + 2;
    localparam int INIT_US  = 3 * (BYTE_US + WAIT_US_LONG + 1) +
                              3 * (BYTE_US + WAIT_US_NORMAL + 1);
    localparam int FRAME_US = NUM_LINES * (LINE_CHARS + 1) * (BYTE_US + WAIT_US_NORMAL + 1) +
                              REFRESH_WAIT_US;
    localparam longint LIMIT_NS =
        longint'(2000) * (BOOT_WAIT_US + INIT_US + SERIAL_MAX_US + NUM_FRAMES * FRAME_US);

    logic         clk;
    logic         rst;
    logic [47:0]  serial_number;
    logic         serial_done;
    logic [7:0]   chance_ascii;
    logic [479:0] msg;
    logic         lcd_rs;
    logic         lcd_en;
    logic [3:0]   lcd_data;
    logic         activated;
    logic         init_done;
    int           frames_done;
    int           value_errs;
    int           timing_errs;
    int           order_errs;
    int           assert_errs;
    integer       seed = 65328;

    lcd2004_driver #(
        .CLK_HZ          (CLK_HZ),
        .BOOT_WAIT_US    (BOOT_WAIT_US),
        .REFRESH_WAIT_US (REFRESH_WAIT_US)
    ) uut (
        .clk             (clk),
        .rst             (rst),
        .serial_number_i (serial_number),
        .serial_done_i   (serial_done),
        .chance_ascii_i  (chance_ascii),
        .msg_i           (msg),
        .lcd_rs_o        (lcd_rs),
        .lcd_en_o        (lcd_en),
        .lcd_data_o      (lcd_data),
        .activated_o     (activated)
    );

    lcd_bus_monitor #(
        .BOOT_WAIT_US    (BOOT_WAIT_US),
        .REFRESH_WAIT_US (REFRESH_WAIT_US)
    ) u_monitor (
        .clk             (clk),
        .rst             (rst),
        .lcd_rs_i        (lcd_rs),
        .lcd_en_i        (lcd_en),
        .lcd_data_i      (lcd_data),
        .activated_i     (activated),
        .serial_done_i   (serial_done),
        .serial_number_i (serial_number),
        .chance_ascii_i  (chance_ascii),
        .msg_i           (msg),
        .init_done_o     (init_done),
        .frames_o        (frames_done),
        .value_errs_o    (value_errs),
        .timing_errs_o   (timing_errs),
        .order_errs_o    (order_errs)
    );

    assign assert_errs = uut.u_sender.u_props.fail_cnt;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // printable ASCII, 0x20..0x7e
    function automatic logic [7:0] random_char();
        return 8'h20 + 8'($unsigned($random(seed)) % 95);
    endfunction

    task automatic apply_random_inputs();
        int i;
        for (i = 0; i < SERIAL_CHARS; i++) begin
            serial_number[8*i +: 8] = random_char();
        end
        for (i = 0; i < MSG_CHARS; i++) begin
            msg[8*i +: 8] = random_char();
        end
        chance_ascii = random_char();
    endtask

    // watchdog
    initial begin
        #(LIMIT_NS);
        $display("timeout: the driver did not finish %0d frames in time", NUM_FRAMES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int f;
        int serial_wait_us;
        rst           = 1'b0;
        serial_done   = 1'b0;
        serial_number = '0;
        chance_ascii  = '0;
        msg           = '0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b1;
        apply_random_inputs();
        wait (init_done);
        serial_wait_us = 100 + $unsigned($random(seed)) % (SERIAL_MAX_US - 100);
        repeat (serial_wait_us * CYC_PER_US) @(posedge clk);
        #2;
        serial_done = 1'b1;
        for (f = 1; f <= NUM_FRAMES; f++) begin
            // the last byte of a frame is followed by the refresh wait
            wait (frames_done >= f);
            @(posedge clk);
            #2;
            if (f < NUM_FRAMES) apply_random_inputs();
        end
        $display("errors: value=%0d timing=%0d protocol=%0d assertion=%0d",
                 value_errs, timing_errs, order_errs, assert_errs);
        if (value_errs + timing_errs + order_errs + assert_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== src.f ====
lcd_pkg.sv
lcd_byte_if.sv
lcd_tick_gen.sv
lcd_char_map.sv
lcd_frame_sequencer.sv
lcd_nibble_sender.sv
lcd2004_driver.sv
lcd_sender_properties.sv
lcd_bus_monitor.sv
tb_lcd2004.sv

// ==== Bender.yml ====
package:
  name: lcd2004_driver

sources:
  - files:
      - lcd_pkg.sv
      - lcd_byte_if.sv
      - lcd_tick_gen.sv
      - lcd_char_map.sv
      - lcd_frame_sequencer.sv
      - lcd_nibble_sender.sv
      - lcd2004_driver.sv
  - target: simulation
    files:
      - lcd_sender_properties.sv
      - lcd_bus_monitor.sv
      - tb_lcd2004.sv
